/* rta_lite.f */
hw/rta_pkg.sv
hw/mmio_regs.sv
hw/triangle_mem.sv
hw/patch_dispatcher.sv
hw/intersect_core.sv
hw/result_collector.sv
hw/rta_top.sv
bench/rta_tb.sv

/* bench/rta_tb.sv */
`timescale 1ns/1ps

module rta_tb
  import rta_pkg::*;
();

  localparam int NUM_IC     = 2;
  localparam int NUM_TRI    = 16;
  localparam int SCREEN_DIM = 16;
  localparam int NPIX       = SCREEN_DIM * SCREEN_DIM;
  localparam int TIMEOUT    = 100;
  localparam int POLL_LIMIT = 2000;

  logic        clk;
  logic        reset;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // Scene as the host believes it is loaded
  int     tx [NUM_TRI][3];
  int     ty [NUM_TRI][3];
  int     tz [NUM_TRI];
  int     errors;
  integer seed;

  rta_top #(
    .NUM_IC(NUM_IC),
    .NUM_TRI(NUM_TRI),
    .SCREEN_DIM(SCREEN_DIM)
  ) uut (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic int urand(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // ============================================================
  // Reference renderer
  // ============================================================
  // (b - a) x (q - a)
  function automatic int edge_val(input int ax, input int ay, input int bx, input int by,
                                  input int qx, input int qy);
    return (bx - ax) * (qy - ay) - (by - ay) * (qx - ax);
  endfunction

  function automatic logic [31:0] ref_pixel(input int p, input int count);
    int px;
    int py;
    int e0;
    int e1;
    int e2;
    int area;
    int best_t;
    int best_z;
    px     = p % SCREEN_DIM;
    py     = p / SCREEN_DIM;
    best_t = -1;
    best_z = 0;
    for (int t = 0; t < count; t++) begin
      e0   = edge_val(tx[t][0], ty[t][0], tx[t][1], ty[t][1], px, py);
      e1   = edge_val(tx[t][1], ty[t][1], tx[t][2], ty[t][2], px, py);
      e2   = edge_val(tx[t][2], ty[t][2], tx[t][0], ty[t][0], px, py);
      area = edge_val(tx[t][0], ty[t][0], tx[t][1], ty[t][1], tx[t][2], ty[t][2]);
      if (area != 0 &&
          ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))) begin
        // Ascending ids mean equal depth keeps the earlier one
        if (best_t < 0 || tz[t] < best_z) begin
          best_t = t;
          best_z = tz[t];
        end
      end
    end
    if (best_t < 0) begin
      return 32'h0;
    end
    return {16'h0, 1'b1, 7'(best_t), 8'(best_z)};
  endfunction

  // Command words in the command register layout
  function automatic logic [31:0] vtx_word(input int t, input int sel, input int x, input int y);
    return {OP_VERTEX, 6'(t), 2'(sel), 8'(x), 8'(y), 6'd0};
  endfunction

  function automatic logic [31:0] start_word(input int count);
    return {OP_START, 7'(count), 23'd0};
  endfunction

  // ============================================================
  // AXI4-Lite host
  // ============================================================
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
    int t;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    #1;
    t = 0;
    // Taken at the next rising edge once awready is up
    while (!(awready && wready) && t < TIMEOUT) begin
      @(negedge clk);
      #1;
      t++;
    end
    if (!(awready && wready)) begin
      errors++;
      $display("Write address %h was never accepted", addr);
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    t = 0;
    while (!bvalid && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!bvalid) begin
      errors++;
      $display("No write response for address %h", addr);
    end
    check("bresp", 32'(2'b00), 32'(bresp));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    int t;
    int hold;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    t = 0;
    while (!arready && t < TIMEOUT) begin
      @(negedge clk);
      #1;
      t++;
    end
    if (!arready) begin
      errors++;
      $display("Read address %h was never accepted", addr);
    end
    @(negedge clk);
    arvalid = 1'b0;
    t = 0;
    while (!rvalid && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!rvalid) begin
      errors++;
      $display("No read data for address %h", addr);
    end
    data = rdata;
    check("rresp", 32'(2'b00), 32'(rresp));
    // Data must hold while the response is stalled
    hold = urand(4);
    repeat (hold) @(negedge clk);
    check($sformatf("rdata stable at %h", addr), data, rdata);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < POLL_LIMIT) begin
      axi_read(ADDR_STATUS, st);
      polls++;
    end
    if (!st[1]) begin
      errors++;
      $display("Frame never finished, done bit stayed low");
    end
  endtask

  // ============================================================
  // Scenes
  // ============================================================
  task automatic load_tri(input int t);
    for (int v = 0; v < 3; v++) begin
      axi_write(ADDR_CMD, vtx_word(t, v, tx[t][v], ty[t][v]));
    end
    axi_write(ADDR_CMD, vtx_word(t, 3, tz[t], 0));
  endtask

  task automatic set_tri(input int t, input int x0, input int y0, input int x1, input int y1,
                         input int x2, input int y2, input int z);
    tx[t] = '{x0, x1, x2};
    ty[t] = '{y0, y1, y2};
    tz[t] = z;
    load_tri(t);
  endtask

  // Coordinates spill a little past the screen edge
  task automatic random_scene();
    for (int t = 0; t < NUM_TRI; t++) begin
      for (int v = 0; v < 3; v++) begin
        tx[t][v] = urand(20);
        ty[t][v] = urand(20);
      end
      // Coarse depths so ties show up
      tz[t] = urand(8) * 32;
      // Some zero-area triangles
      if (t % 5 == 4) begin
        tx[t][2] = tx[t][1];
        ty[t][2] = ty[t][1];
      end
      load_tri(t);
    end
  endtask

  task automatic check_frame(input string name, input int count);
    logic [31:0] d;
    for (int p = 0; p < NPIX; p++) begin
      axi_read(ADDR_RESULT_BASE + 12'(4 * p), d);
      check($sformatf("%s pixel %0d", name, p), ref_pixel(p, count), d);
    end
  endtask

  initial begin
    logic [31:0] d;
    seed    = 32'h81accb63;
    errors  = 0;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hf;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle state and unmapped space
    axi_read(ADDR_STATUS, d);
    check("status after reset", 32'h0, d);
    axi_read(12'h008, d);
    check("unmapped read", 32'h0, d);
    axi_read(12'h800, d);
    check("read past results", 32'h0, d);

    // Random scene with the full triangle count
    random_scene();
    axi_write(ADDR_CMD, start_word(NUM_TRI));
    wait_done();
    check_frame("random scene", NUM_TRI);
    axi_read(ADDR_STATUS, d);
    check("done after frame", 32'h2, d);

    // Empty frame
    axi_write(ADDR_CMD, start_word(0));
    wait_done();
    check_frame("empty frame", 0);

    // Depth tie between ids 3 and 5 with id 4 farther away
    for (int t = 0; t < 3; t++) begin
      set_tri(t, 0, 0, 0, 0, 0, 0, 0);
    end
    set_tri(3, 0, 0, 15, 0, 0, 15, 40);
    set_tri(4, 0, 0, 0, 15, 15, 15, 90);
    set_tri(5, 2, 2, 2, 14, 14, 2, 40);
    axi_write(ADDR_CMD, start_word(6));
    wait_done();
    check_frame("depth tie", 6);
    axi_read(ADDR_RESULT_BASE + 12'(4 * (5 * SCREEN_DIM + 5)), d);
    check("tie winner", {16'h0, 1'b1, 7'd3, 8'd40}, d);

    // Commands during a frame are dropped
    axi_write(ADDR_CMD, start_word(6));
    axi_read(ADDR_STATUS, d);
    check("busy after start", 32'h1, d);
    axi_write(ADDR_CMD, vtx_word(3, 0, 9, 9));
    axi_write(ADDR_CMD, start_word(NUM_TRI));
    wait_done();
    axi_read(ADDR_STATUS, d);
    check("single done", 32'h2, d);
    check_frame("busy commands ignored", 6);
    axi_read(ADDR_STATUS, d);
    check("no extra frame", 32'h2, d);

    // A new scene whose start clears done
    random_scene();
    axi_write(ADDR_CMD, start_word(NUM_TRI));
    axi_read(ADDR_STATUS, d);
    check("done cleared by start", 32'h1, d);
    wait_done();
    check_frame("second scene", NUM_TRI);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* hw/rta_top.sv */
`timescale 1ns/1ps

module rta_top
  import rta_pkg::*;
#(
  parameter int NUM_IC     = 2,
  parameter int NUM_TRI    = 16,
  parameter int SCREEN_DIM = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [11:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [11:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  localparam int TRI_W = (NUM_TRI > 1) ? $clog2(NUM_TRI) : 1;
  localparam int PIX_W = 2 * $clog2(SCREEN_DIM);

  // ==========================================================
  // Interconnect
  // ==========================================================
  // Register front end to memory and frame control
  logic               tri_we;
  logic [TRI_W-1:0]   tri_addr;
  logic [1:0]         tri_vtx_sel;
  logic [COORD_W-1:0] tri_x;
  logic [COORD_W-1:0] tri_y;
  logic               frame_start;
  logic [6:0]         tri_count;
  logic               frame_done;
  logic [PIX_W-1:0]   res_raddr;
  logic [RES_W-1:0]   res_rdata;

  // Per-core triangle reads
  logic [TRI_W-1:0]   rd_tri [NUM_IC];
  logic [COORD_W-1:0] rd_v0x [NUM_IC];
  logic [COORD_W-1:0] rd_v0y [NUM_IC];
  logic [COORD_W-1:0] rd_v1x [NUM_IC];
  logic [COORD_W-1:0] rd_v1y [NUM_IC];
  logic [COORD_W-1:0] rd_v2x [NUM_IC];
  logic [COORD_W-1:0] rd_v2y [NUM_IC];
  logic [COORD_W-1:0] rd_z   [NUM_IC];

  // Jobs in, results out
  logic               job_valid [NUM_IC];
  logic               job_ready [NUM_IC];
  logic [PIX_W-1:0]   job_pixel;
  logic               res_valid [NUM_IC];
  logic               res_ready [NUM_IC];
  logic [PIX_W-1:0]   res_pixel [NUM_IC];
  logic [RES_W-1:0]   res_word  [NUM_IC];

  mmio_regs #(
    .NUM_TRI(NUM_TRI),
    .SCREEN_DIM(SCREEN_DIM)
  ) u_mmio (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .tri_we(tri_we), .tri_addr(tri_addr), .tri_vtx_sel(tri_vtx_sel),
    .tri_x(tri_x), .tri_y(tri_y),
    .frame_start(frame_start), .tri_count(tri_count), .frame_done(frame_done),
    .res_raddr(res_raddr), .res_rdata(res_rdata)
  );

  triangle_mem #(
    .NUM_IC(NUM_IC),
    .NUM_TRI(NUM_TRI)
  ) u_tri_mem (
    .clk(clk), .reset(reset),
    .tri_we(tri_we), .tri_addr(tri_addr), .tri_vtx_sel(tri_vtx_sel),
    .tri_x(tri_x), .tri_y(tri_y),
    .rd_tri(rd_tri),
    .rd_v0x(rd_v0x), .rd_v0y(rd_v0y), .rd_v1x(rd_v1x), .rd_v1y(rd_v1y),
    .rd_v2x(rd_v2x), .rd_v2y(rd_v2y), .rd_z(rd_z)
  );

  patch_dispatcher #(
    .NUM_IC(NUM_IC),
    .SCREEN_DIM(SCREEN_DIM)
  ) u_dispatch (
    .clk(clk), .reset(reset), .frame_start(frame_start),
    .job_valid(job_valid), .job_ready(job_ready), .job_pixel(job_pixel)
  );

  // Intersection cores
  for (genvar c = 0; c < NUM_IC; c++) begin : g_core
    intersect_core #(
      .NUM_TRI(NUM_TRI),
      .SCREEN_DIM(SCREEN_DIM)
    ) u_core (
      .clk(clk), .reset(reset), .tri_count(tri_count),
      .job_valid(job_valid[c]), .job_ready(job_ready[c]), .job_pixel(job_pixel),
      .rd_tri(rd_tri[c]),
      .rd_v0x(rd_v0x[c]), .rd_v0y(rd_v0y[c]), .rd_v1x(rd_v1x[c]), .rd_v1y(rd_v1y[c]),
      .rd_v2x(rd_v2x[c]), .rd_v2y(rd_v2y[c]), .rd_z(rd_z[c]),
      .res_valid(res_valid[c]), .res_ready(res_ready[c]),
      .res_pixel(res_pixel[c]), .res_word(res_word[c])
    );
  end

  result_collector #(
    .NUM_IC(NUM_IC),
    .SCREEN_DIM(SCREEN_DIM)
  ) u_collect (
    .clk(clk), .reset(reset), .frame_start(frame_start),
    .res_valid(res_valid), .res_ready(res_ready),
    .res_pixel(res_pixel), .res_word(res_word),
    .res_raddr(res_raddr), .res_rdata(res_rdata), .frame_done(frame_done)
  );

endmodule

/* hw/result_collector.sv */
`timescale 1ns/1ps

module result_collector
  import rta_pkg::*;
#(
  parameter int NUM_IC     = 2,
  parameter int SCREEN_DIM = 16,
  localparam int PIX_W     = 2 * $clog2(SCREEN_DIM)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             frame_start,
  input  logic             res_valid [NUM_IC],
  output logic             res_ready [NUM_IC],
  input  logic [PIX_W-1:0] res_pixel [NUM_IC],
  input  logic [RES_W-1:0] res_word  [NUM_IC],
  input  logic [PIX_W-1:0] res_raddr,
  output logic [RES_W-1:0] res_rdata,
  output logic             frame_done
);

  localparam int NPIX = SCREEN_DIM * SCREEN_DIM;

  logic [RES_W-1:0] ram [NPIX];
  logic [PIX_W:0]   count;
  int               sel;
  logic             found;

  // Fixed priority, lowest core index first
  always_comb begin
    sel   = 0;
    found = 1'b0;
    for (int k = NUM_IC - 1; k >= 0; k--) begin
      if (res_valid[k]) begin
        sel   = k;
        found = 1'b1;
      end
    end
    for (int k = 0; k < NUM_IC; k++) begin
      res_ready[k] = found && (sel == k);
    end
  end

  // Result RAM, synchronous read for the host
  always_ff @(posedge clk) begin
    if (found) begin
      ram[res_pixel[sel]] <= res_word[sel];
    end
    res_rdata <= ram[res_raddr];
  end

  // Stored-result count, done after the last pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      count      <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (frame_start) begin
        count <= '0;
      end else if (found) begin
        count <= count + 1'b1;
        if (count == (PIX_W + 1)'(NPIX - 1)) begin
          frame_done <= 1'b1;
        end
      end
    end
  end

endmodule

/* hw/intersect_core.sv */
`timescale 1ns/1ps

module intersect_core
  import rta_pkg::*;
#(
  parameter int NUM_TRI    = 16,
  parameter int SCREEN_DIM = 16,
  localparam int TRI_W     = (NUM_TRI > 1) ? $clog2(NUM_TRI) : 1,
  localparam int PIX_W     = 2 * $clog2(SCREEN_DIM)
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [6:0]         tri_count,
  // Job from the dispatcher
  input  logic               job_valid,
  output logic               job_ready,
  input  logic [PIX_W-1:0]   job_pixel,
  // Triangle memory port
  output logic [TRI_W-1:0]   rd_tri,
  input  logic [COORD_W-1:0] rd_v0x,
  input  logic [COORD_W-1:0] rd_v0y,
  input  logic [COORD_W-1:0] rd_v1x,
  input  logic [COORD_W-1:0] rd_v1y,
  input  logic [COORD_W-1:0] rd_v2x,
  input  logic [COORD_W-1:0] rd_v2y,
  input  logic [COORD_W-1:0] rd_z,
  // Result to the collector
  output logic               res_valid,
  input  logic               res_ready,
  output logic [PIX_W-1:0]   res_pixel,
  output logic [RES_W-1:0]   res_word
);

  localparam int DIM_W = PIX_W / 2;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_DONE = 2'd2;

  logic [1:0]               state;
  logic [PIX_W-1:0]         pix_q;
  logic [6:0]               idx;
  logic                     best_hit;
  logic [6:0]               best_id;
  logic [COORD_W-1:0]       best_z;
  logic [COORD_W-1:0]       px;
  logic [COORD_W-1:0]       py;
  logic signed [EDGE_W-1:0] e0;
  logic signed [EDGE_W-1:0] e1;
  logic signed [EDGE_W-1:0] e2;
  logic signed [EDGE_W-1:0] area;
  logic                     hit;

  // (b - a) x (p - a)
  function automatic logic signed [EDGE_W-1:0] edge_fn(
    input logic [COORD_W-1:0] ax, input logic [COORD_W-1:0] ay,
    input logic [COORD_W-1:0] bx, input logic [COORD_W-1:0] by,
    input logic [COORD_W-1:0] qx, input logic [COORD_W-1:0] qy);
    logic signed [COORD_W:0] dx;
    logic signed [COORD_W:0] dy;
    logic signed [COORD_W:0] rx;
    logic signed [COORD_W:0] ry;
    dx = $signed({1'b0, bx}) - $signed({1'b0, ax});
    dy = $signed({1'b0, by}) - $signed({1'b0, ay});
    rx = $signed({1'b0, qx}) - $signed({1'b0, ax});
    ry = $signed({1'b0, qy}) - $signed({1'b0, ay});
    return dx * ry - dy * rx;
  endfunction

  // ==========================================================
  // Edge test for the current triangle
  // ==========================================================
  // x from the low index bits, y from the high ones
  assign px = COORD_W'(pix_q[DIM_W-1:0]);
  assign py = COORD_W'(pix_q[PIX_W-1:DIM_W]);

  assign rd_tri = idx[TRI_W-1:0];
  assign e0     = edge_fn(rd_v0x, rd_v0y, rd_v1x, rd_v1y, px, py);
  assign e1     = edge_fn(rd_v1x, rd_v1y, rd_v2x, rd_v2y, px, py);
  assign e2     = edge_fn(rd_v2x, rd_v2y, rd_v0x, rd_v0y, px, py);
  assign area   = edge_fn(rd_v0x, rd_v0y, rd_v1x, rd_v1y, rd_v2x, rd_v2y);

  // Either winding, zero area rejected
  assign hit = (area != 0) &&
               ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0));

  assign job_ready = (state == S_IDLE);
  assign res_pixel = pix_q;
  assign res_word  = {best_hit, best_id, best_z};

  // Control FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      res_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (job_valid) begin
            state <= S_RUN;
          end
        end
        // Extra cycle after the last triangle
        S_RUN: begin
          if (idx == tri_count) begin
            state     <= S_DONE;
            res_valid <= 1'b1;
          end
        end
        S_DONE: begin
          if (res_ready) begin
            state     <= S_IDLE;
            res_valid <= 1'b0;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Nearest hit, ties keep the earlier (lower) id
  always_ff @(posedge clk) begin
    if (state == S_IDLE && job_valid) begin
      pix_q    <= job_pixel;
      idx      <= '0;
      best_hit <= 1'b0;
      best_id  <= '0;
      best_z   <= '0;
    end else if (state == S_RUN && idx != tri_count) begin
      idx <= idx + 1'b1;
      if (hit && (!best_hit || rd_z < best_z)) begin
        best_hit <= 1'b1;
        best_id  <= idx;
        best_z   <= rd_z;
      end
    end
  end

  a_res_stable: assert property (@(posedge clk) disable iff (reset)
    res_valid && !res_ready |=> $stable(res_word));

endmodule

/* hw/patch_dispatcher.sv */
`timescale 1ns/1ps

module patch_dispatcher #(
  parameter int NUM_IC     = 2,
  parameter int SCREEN_DIM = 16,
  localparam int PIX_W     = 2 * $clog2(SCREEN_DIM)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             frame_start,
  output logic             job_valid [NUM_IC],
  input  logic             job_ready [NUM_IC],
  output logic [PIX_W-1:0] job_pixel
);

  localparam int NPIX = SCREEN_DIM * SCREEN_DIM;
  localparam int IC_W = (NUM_IC > 1) ? $clog2(NUM_IC) : 1;

  logic             active;
  logic [PIX_W-1:0] next_pix;
  logic [IC_W-1:0]  rr_ptr;
  int               sel;
  logic             found;

  // First idle core at or after the round-robin pointer
  always_comb begin
    int idx;
    sel   = 0;
    found = 1'b0;
    for (int k = 0; k < NUM_IC; k++) begin
      idx = (int'(rr_ptr) + k) % NUM_IC;
      if (!found && job_ready[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
  end

  // Offer to one core only
  always_comb begin
    for (int k = 0; k < NUM_IC; k++) begin
      job_valid[k] = active && found && (sel == k);
    end
  end

  assign job_pixel = next_pix;

  // Pixel walk, one issue per cycle at most
  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      next_pix <= '0;
      rr_ptr   <= '0;
    end else if (frame_start) begin
      active   <= 1'b1;
      next_pix <= '0;
    end else if (active && found) begin
      next_pix <= next_pix + 1'b1;
      rr_ptr   <= IC_W'((sel + 1) % NUM_IC);
      // Last pixel handed out
      if (next_pix == PIX_W'(NPIX - 1)) begin
        active <= 1'b0;
      end
    end
  end

  for (genvar k = 0; k < NUM_IC; k++) begin : g_chk
    a_job_to_idle: assert property (@(posedge clk) disable iff (reset)
      job_valid[k] |-> job_ready[k]);
  end

endmodule

/* hw/triangle_mem.sv */
`timescale 1ns/1ps

module triangle_mem
  import rta_pkg::*;
#(
  parameter int NUM_IC   = 2,
  parameter int NUM_TRI  = 16,
  localparam int TRI_W   = (NUM_TRI > 1) ? $clog2(NUM_TRI) : 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               tri_we,
  input  logic [TRI_W-1:0]   tri_addr,
  input  logic [1:0]         tri_vtx_sel,
  input  logic [COORD_W-1:0] tri_x,
  input  logic [COORD_W-1:0] tri_y,
  // One read port per core
  input  logic [TRI_W-1:0]   rd_tri  [NUM_IC],
  output logic [COORD_W-1:0] rd_v0x  [NUM_IC],
  output logic [COORD_W-1:0] rd_v0y  [NUM_IC],
  output logic [COORD_W-1:0] rd_v1x  [NUM_IC],
  output logic [COORD_W-1:0] rd_v1y  [NUM_IC],
  output logic [COORD_W-1:0] rd_v2x  [NUM_IC],
  output logic [COORD_W-1:0] rd_v2y  [NUM_IC],
  output logic [COORD_W-1:0] rd_z    [NUM_IC]
);

  // Vertex coordinates per triangle and a single depth
  logic [COORD_W-1:0] vx [NUM_TRI][3];
  logic [COORD_W-1:0] vy [NUM_TRI][3];
  logic [COORD_W-1:0] vz [NUM_TRI];

  // Cleared entries are degenerate and never hit
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int t = 0; t < NUM_TRI; t++) begin
        for (int v = 0; v < 3; v++) begin
          vx[t][v] <= '0;
          vy[t][v] <= '0;
        end
        vz[t] <= '0;
      end
    end else if (tri_we) begin
      if (tri_vtx_sel == 2'd3) begin
        vz[tri_addr] <= tri_x;
      end else begin
        vx[tri_addr][tri_vtx_sel] <= tri_x;
        vy[tri_addr][tri_vtx_sel] <= tri_y;
      end
    end
  end

  // Combinational reads
  for (genvar c = 0; c < NUM_IC; c++) begin : g_rd
    assign rd_v0x[c] = vx[rd_tri[c]][0];
    assign rd_v0y[c] = vy[rd_tri[c]][0];
    assign rd_v1x[c] = vx[rd_tri[c]][1];
    assign rd_v1y[c] = vy[rd_tri[c]][1];
    assign rd_v2x[c] = vx[rd_tri[c]][2];
    assign rd_v2y[c] = vy[rd_tri[c]][2];
    assign rd_z[c]   = vz[rd_tri[c]];
  end

endmodule

/* hw/mmio_regs.sv */
`timescale 1ns/1ps

module mmio_regs
  import rta_pkg::*;
#(
  parameter int NUM_TRI    = 16,
  parameter int SCREEN_DIM = 16,
  localparam int TRI_W     = (NUM_TRI > 1) ? $clog2(NUM_TRI) : 1,
  localparam int PIX_W     = 2 * $clog2(SCREEN_DIM)
) (
  input  logic               clk,
  input  logic               reset,
  // AXI4-Lite slave
  input  logic [11:0]        awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [31:0]        wdata,
  input  logic [3:0]         wstrb,
  input  logic               wvalid,
  output logic               wready,
  output logic [1:0]         bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic [11:0]        araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [31:0]        rdata,
  output logic [1:0]         rresp,
  output logic               rvalid,
  input  logic               rready,
  // Triangle memory write port
  output logic               tri_we,
  output logic [TRI_W-1:0]   tri_addr,
  output logic [1:0]         tri_vtx_sel,
  output logic [COORD_W-1:0] tri_x,
  output logic [COORD_W-1:0] tri_y,
  // Frame control
  output logic               frame_start,
  output logic [6:0]         tri_count,
  input  logic               frame_done,
  // Result RAM read port
  output logic [PIX_W-1:0]   res_raddr,
  input  logic [RES_W-1:0]   res_rdata
);

  localparam int NPIX = SCREEN_DIM * SCREEN_DIM;

  cmd_word_u        cmd;
  logic             cmd_wr;
  logic             cmd_start;
  logic             busy;
  logic             done;
  logic             rd_fire;
  logic             rd_in_res;
  logic [11:0]      res_off;
  logic             rd_is_res_q;
  logic [31:0]      rd_word_q;
  logic [PIX_W-1:0] raddr_q;

  // ==========================================================
  // Write channel and command decode
  // ==========================================================
  // Address and data taken together, one per response
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign bresp   = 2'b00;

  assign cmd    = wdata;
  // Full-word writes to the command register only
  assign cmd_wr = awready && (awaddr == ADDR_CMD) && (&wstrb);

  // Vertex writes go straight to the triangle memory
  assign tri_we      = cmd_wr && !busy && (cmd.vtx.op == OP_VERTEX) &&
                       (cmd.vtx.tri_id < NUM_TRI);
  assign tri_addr    = cmd.vtx.tri_id[TRI_W-1:0];
  assign tri_vtx_sel = cmd.vtx.vtx_sel;
  assign tri_x       = cmd.vtx.x;
  assign tri_y       = cmd.vtx.y;

  assign cmd_start = cmd_wr && !busy && (cmd.start.op == OP_START);

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid      <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= cmd_start;
      if (awready) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      // Frame end clears busy
      if (frame_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else if (cmd_start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end
    end
  end

  // Count held for the whole frame, clamped to the memory size
  always_ff @(posedge clk) begin
    if (cmd_start) begin
      tri_count <= (cmd.start.tri_count > NUM_TRI) ? 7'(NUM_TRI) : cmd.start.tri_count;
    end
  end

  // ==========================================================
  // Read channel
  // ==========================================================
  assign arready   = !rvalid;
  assign rd_fire   = arvalid && arready;
  assign rresp     = 2'b00;
  assign res_off   = araddr - ADDR_RESULT_BASE;
  assign rd_in_res = (araddr >= ADDR_RESULT_BASE) && (res_off[11:2] < NPIX);

  // Keep the RAM address while the response waits, so res_rdata holds
  assign res_raddr = rd_fire ? res_off[PIX_W+1:2] : raddr_q;
  assign rdata     = rd_is_res_q ? 32'(res_rdata) : rd_word_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_is_res_q <= rd_in_res;
      raddr_q     <= res_off[PIX_W+1:2];
      // Unmapped reads give zero
      rd_word_q   <= (araddr == ADDR_STATUS) ? {30'b0, done, busy} : 32'b0;
    end
  end

  // Write response holds until taken
  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid);

endmodule

/* hw/rta_pkg.sv */
package rta_pkg;

  // ==========================================================
  // Command opcodes and the command word
  // ==========================================================
  typedef enum logic [1:0] {
    OP_NOP    = 2'd0,
    OP_VERTEX = 2'd1,
    OP_START  = 2'd2
  } op_e;

  // Coordinate and depth width
  localparam int COORD_W = 8;
  // Signed edge function value
  localparam int EDGE_W = 18;
  // Result word {hit, tri id, depth}
  localparam int RES_W = 16;

  // One command word, two views sharing the opcode field
  typedef union packed {
    struct packed {
      op_e                op;
      logic [5:0]         tri_id;
      logic [1:0]         vtx_sel;  // 3 writes depth from x
      logic [COORD_W-1:0] x;
      logic [COORD_W-1:0] y;
      logic [5:0]         spare;
    } vtx;
    struct packed {
      op_e         op;
      logic [6:0]  tri_count;
      logic [22:0] spare;
    } start;
  } cmd_word_u;

  // ==========================================================
  // Register map
  // ==========================================================
  localparam logic [11:0] ADDR_CMD         = 12'h000;
  localparam logic [11:0] ADDR_STATUS      = 12'h004;  // bit 0 busy, bit 1 done
  localparam logic [11:0] ADDR_RESULT_BASE = 12'h400;  // one word per pixel

endpackage
